// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_attention
FILELIST  = list.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(filter-out +incdir+%,$(shell cat $(FILELIST))) attn_macros.svh

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'Test passed'

clean:
	rm -rf $(OBJ_DIR)

// ==== attention_top.sv ====
// Self-attention front end
`timescale 1ns/1ps
`default_nettype none

module attention_top
	import attn_types_pkg::*;
(
	input  wire        clk,
	input  wire        reset_n,
	input  wire        dut_valid,
	output logic       dut_ready,

	// Input memory
	output addr_t      input_read_address,
	input  wire data_t input_read_data,

	// Weight memory
	output addr_t      weight_read_address,
	input  wire data_t weight_read_data,

	// Result memory
	output logic       result_write_enable,
	output addr_t      result_write_address,
	output data_t      result_write_data,
	output addr_t      result_read_address,
	input  wire data_t result_read_data,

	// Scratchpad memory
	output logic       scratchpad_write_enable,
	output addr_t      scratchpad_write_address,
	output data_t      scratchpad_write_data,
	output addr_t      scratchpad_read_address,
	input  wire data_t scratchpad_read_data
);

	logic  wr_en;
	addr_t wr_addr;
	data_t wr_data;

	seq_if  seq_bus ();
	oper_if oper_bus ();

	attn_sequencer u_seq (
		.clk              (clk),
		.reset_n          (reset_n),
		.dut_valid        (dut_valid),
		.dut_ready        (dut_ready),
		.input_read_data  (input_read_data),
		.weight_read_data (weight_read_data),
		.seq              (seq_bus.seq)
	);

	operand_addr_gen u_agen (
		.clk                     (clk),
		.reset_n                 (reset_n),
		.seq                     (seq_bus.agen),
		.oper                    (oper_bus.agen),
		.input_read_address      (input_read_address),
		.weight_read_address     (weight_read_address),
		.result_read_address     (result_read_address),
		.scratchpad_read_address (scratchpad_read_address)
	);

	mac_writeback u_mac (
		.clk                  (clk),
		.reset_n              (reset_n),
		.oper                 (oper_bus.mac),
		.input_read_data      (input_read_data),
		.weight_read_data     (weight_read_data),
		.result_read_data     (result_read_data),
		.scratchpad_read_data (scratchpad_read_data),
		.write_enable         (wr_en),
		.write_address        (wr_addr),
		.write_data           (wr_data)
	);

	// Scratchpad mirrors every result write
	assign result_write_enable      = wr_en;
	assign result_write_address     = wr_addr;
	assign result_write_data        = wr_data;
	assign scratchpad_write_enable  = wr_en;
	assign scratchpad_write_address = wr_addr;
	assign scratchpad_write_data    = wr_data;

endmodule

`default_nettype wire

// ==== attn_checker.sv ====
// Result write checker
`timescale 1ns/1ps
`default_nettype none

`include "attn_macros.svh"

module attn_checker
	import attn_types_pkg::*;
(
	input  wire        clk,
	input  wire        reset_n,
	input  wire        dut_ready,
	input  wire        result_write_enable,
	input  wire addr_t result_write_address,
	input  wire data_t result_write_data,
	input  wire        scratchpad_write_enable,
	input  wire addr_t scratchpad_write_address,
	input  wire data_t scratchpad_write_data,
	input  wire data_t input_mem [2**`ADDR_WIDTH],
	input  wire data_t weight_mem [2**`ADDR_WIDTH],
	output int         error_count,
	output int         run_writes
);

	int   dim_n;
	int   dim_d;
	int   dim_e;
	int   expect_total;
	logic active;  // Between ready fall and ready rise
	logic ready_q;
	logic write_q;

	initial begin
		error_count = 0;
		run_writes  = 0;
		active      = 1'b0;
		ready_q     = 1'b0;
		write_q     = 1'b0;
	end

	// ------------------------------
	// Reference model
	// ------------------------------

	// Element (r, c) of projection p, I times the p-th weight
	function automatic data_t proj_elem(int p, int r, int c);
		data_t acc;
		acc = '0;
		for (int k = 0; k < dim_d; k++)
			acc += input_mem[addr_t'(1 + r * dim_d + k)]
				* weight_mem[addr_t'(1 + p * dim_d * dim_e + k * dim_e + c)];
		return acc;
	endfunction

	// Q, K and V first, then S row-major
	function automatic data_t expected_at(int idx);
		int    ne;
		int    s_idx;
		data_t acc;
		ne  = dim_n * dim_e;
		acc = '0;
		if (idx < 3 * ne)
			return proj_elem(idx / ne, (idx % ne) / dim_e, idx % dim_e);
		s_idx = idx - 3 * ne;
		for (int k = 0; k < dim_e; k++)
			acc += proj_elem(0, s_idx / dim_n, k) * proj_elem(1, s_idx % dim_n, k); // Q row, K row
		return acc;
	endfunction

	task automatic check_write();
		data_t want;
		if (!active || dut_ready) begin
			$display("Write strobe at %0t while no run was in progress", $time);
			error_count++;
		end else if (run_writes >= expect_total) begin
			$display("[FAIL] %0t: extra write to address %0d", $time, result_write_address);
			error_count++;
		end else begin
			want = expected_at(run_writes);
			if (result_write_address !== addr_t'(run_writes)) begin
				$display("[FAIL] %0t: write address %0d, expected %0d", $time,
					result_write_address, run_writes);
				error_count++;
			end
			if (result_write_data !== want) begin
				$display("[FAIL] %0t: word %0d is %0d, expected %0d", $time,
					run_writes, result_write_data, want);
				error_count++;
			end
		end
		// Scratchpad mirror
		if (scratchpad_write_address !== result_write_address
			|| scratchpad_write_data !== result_write_data) begin
			$display("[FAIL] %0t: scratchpad write %0d/%0d differs from result write", $time,
				scratchpad_write_address, scratchpad_write_data);
			error_count++;
		end
		run_writes++;
	endtask

	task automatic close_run();
		active = 1'b0;
		if (run_writes != expect_total) begin
			$display("[FAIL] %0t: %0d writes in run, expected %0d", $time,
				run_writes, expect_total);
			error_count++;
		end
		if (!write_q) begin
			$display("dut_ready rose at %0t without a write strobe one cycle before", $time);
			error_count++;
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		if (reset_n) begin
			if (ready_q && !dut_ready) begin
				dim_n        = int'(input_mem[0][31:16]);
				dim_d        = int'(input_mem[0][15:0]);
				dim_e        = int'(weight_mem[0][15:0]);
				expect_total = 3 * dim_n * dim_e + dim_n * dim_n;
				run_writes   = 0;
				active       = 1'b1;
			end
			if (scratchpad_write_enable !== result_write_enable) begin
				$display("Scratchpad and result write enables differ at %0t", $time);
				error_count++;
			end
			if (result_write_enable === 1'b1)
				check_write();
			if (!ready_q && dut_ready && active)
				close_run();
		end
		ready_q = dut_ready;
		write_q = result_write_enable;
	end

endmodule

`default_nettype wire

// ==== attn_ctrl_pkg.sv ====
// Sequencer control encodings
`default_nettype none

package attn_ctrl_pkg;

	// Matrix being computed, in issue order
	typedef enum logic [1:0] {
		PH_Q,
		PH_K,
		PH_V,
		PH_S
	} phase_t;

	typedef enum logic [2:0] {
		ST_IDLE,   // Waiting for dut_valid
		ST_HEADER, // Dimension read and capture
		ST_RUN,    // One product term per cycle
		ST_DRAIN,  // Pipeline flush after a phase
		ST_DONE
	} seq_state_t;

endpackage

`default_nettype wire

// ==== attn_macros.svh ====
// Attention datapath widths
`ifndef ATTN_MACROS_SVH
`define ATTN_MACROS_SVH

// Memory bus
`define ADDR_WIDTH 16
`define DATA_WIDTH 32

// Header word splits into rows and columns
`define DIM_WIDTH (`DATA_WIDTH / 2)

// ------------------------------
// Pipeline
// ------------------------------
`define READ_LATENCY 1
`define PIPE_DEPTH (`READ_LATENCY + 2) // Address register, memory, accumulate

`endif

// ==== attn_sequencer.sv ====
// Attention loop sequencer
`timescale 1ns/1ps
`default_nettype none

`include "attn_macros.svh"

module attn_sequencer
	import attn_types_pkg::*, attn_ctrl_pkg::*;
(
	input  wire        clk,
	input  wire        reset_n,
	input  wire        dut_valid,
	output logic       dut_ready,
	input  wire data_t input_read_data,
	input  wire data_t weight_read_data,
	seq_if.seq         seq
);

	localparam int DRAIN_W = $clog2(`PIPE_DEPTH + 1);

	seq_state_t         state, state_next;
	logic               ready_r;
	logic               hdr_cnt;   // Header read, then capture
	logic [DRAIN_W-1:0] drain_cnt;
	phase_t             phase;
	dim_t               row, col, inner;
	dim_t               dim_n, dim_d, dim_e;

	dim_t inner_lim, col_lim;
	logic inner_end, col_end, row_end, phase_end, drain_end;

	// Loop limits per phase
	always_comb begin
		if (phase == PH_S) begin
			inner_lim = dim_e;
			col_lim   = dim_n; // S is N by N
		end else begin
			inner_lim = dim_d;
			col_lim   = dim_e;
		end
	end

	assign inner_end = (inner == inner_lim - dim_t'(1));
	assign col_end   = (col == col_lim - dim_t'(1));
	assign row_end   = (row == dim_n - dim_t'(1));
	assign phase_end = inner_end && col_end && row_end;
	assign drain_end = (drain_cnt == DRAIN_W'(`PIPE_DEPTH - 1));

	// ------------------------------
	// FSM
	// ------------------------------
	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE, ST_DONE: begin
				if (dut_valid && ready_r)
					state_next = ST_HEADER;
				else
					state_next = ST_IDLE;
			end
			ST_HEADER: if (hdr_cnt) state_next = ST_RUN;
			ST_RUN:    if (phase_end) state_next = ST_DRAIN;
			ST_DRAIN: begin
				if (drain_end)
					state_next = (phase == PH_S) ? ST_DONE : ST_RUN;
			end
			default: state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state     <= ST_IDLE;
			ready_r   <= 1'b0;
			hdr_cnt   <= 1'b0;
			drain_cnt <= '0;
			phase     <= PH_Q;
			row       <= '0;
			col       <= '0;
			inner     <= '0;
		end else begin
			state   <= state_next;
			ready_r <= (state_next == ST_IDLE) || (state_next == ST_DONE);
			case (state)
				ST_HEADER: hdr_cnt <= ~hdr_cnt;
				ST_RUN: begin
					drain_cnt <= '0;
					// Inner fastest, then column, then row
					if (inner_end) begin
						inner <= '0;
						if (col_end) begin
							col <= '0;
							row <= row_end ? '0 : row + dim_t'(1);
						end else begin
							col <= col + dim_t'(1);
						end
					end else begin
						inner <= inner + dim_t'(1);
					end
				end
				ST_DRAIN: begin
					drain_cnt <= drain_cnt + DRAIN_W'(1);
					if (drain_end)
						phase <= phase_t'(phase + 2'd1);
				end
				default: begin
					hdr_cnt <= 1'b0;
					phase   <= PH_Q;
				end
			endcase
		end
	end

	// Header word 0 holds rows above columns
	always_ff @(posedge clk) begin
		if (state == ST_HEADER && hdr_cnt) begin
			dim_n <= input_read_data[2*`DIM_WIDTH-1:`DIM_WIDTH];
			dim_d <= input_read_data[`DIM_WIDTH-1:0];
			dim_e <= weight_read_data[`DIM_WIDTH-1:0];
		end
	end

	assign dut_ready = ready_r;

	assign seq.phase = phase;
	assign seq.row   = row;
	assign seq.col   = col;
	assign seq.inner = inner;
	assign seq.dim_n = dim_n;
	assign seq.dim_d = dim_d;
	assign seq.dim_e = dim_e;
	assign seq.issue = (state == ST_RUN);
	assign seq.first = (inner == '0);
	assign seq.last  = inner_end;

endmodule

`default_nettype wire

// ==== attn_types_pkg.sv ====
// Datapath vector types
`default_nettype none

`include "attn_macros.svh"

package attn_types_pkg;

	// Memory address
	typedef logic [`ADDR_WIDTH-1:0] addr_t;

	// Memory word, also the accumulator
	typedef logic signed [`DATA_WIDTH-1:0] data_t;

	// Row or column count and loop index
	typedef logic [`DIM_WIDTH-1:0] dim_t;

endpackage

`default_nettype wire

// ==== list.f ====
+incdir+.
attn_types_pkg.sv
attn_ctrl_pkg.sv
seq_if.sv
oper_if.sv
attn_sequencer.sv
operand_addr_gen.sv
mac_writeback.sv
attention_top.sv
attn_checker.sv
tb_attention.sv

// ==== mac_writeback.sv ====
// Multiply-accumulate and writeback
`timescale 1ns/1ps
`default_nettype none

`include "attn_macros.svh"

module mac_writeback
	import attn_types_pkg::*, attn_ctrl_pkg::*;
(
	input  wire        clk,
	input  wire        reset_n,
	oper_if.mac        oper,
	input  wire data_t input_read_data,
	input  wire data_t weight_read_data,
	input  wire data_t result_read_data,
	input  wire data_t scratchpad_read_data,
	output logic       write_enable,
	output addr_t      write_address,
	output data_t      write_data
);

	localparam int TAIL = `READ_LATENCY - 1;

	logic [`READ_LATENCY-1:0] valid_q, first_q, last_q, restart_q;
	phase_t phase_q [`READ_LATENCY];
	data_t  op_a, op_b, product, sum, acc;
	addr_t  wr_cnt, base;

	// Tag follows the memory read latency
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid_q   <= '0;
			restart_q <= '0;
		end else begin
			valid_q[0]   <= oper.valid;
			restart_q[0] <= oper.restart;
			for (int i = 1; i < `READ_LATENCY; i++) begin
				valid_q[i]   <= valid_q[i-1];
				restart_q[i] <= restart_q[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		first_q[0] <= oper.first;
		last_q[0]  <= oper.last;
		phase_q[0] <= oper.phase;
		for (int i = 1; i < `READ_LATENCY; i++) begin
			first_q[i] <= first_q[i-1];
			last_q[i]  <= last_q[i-1];
			phase_q[i] <= phase_q[i-1];
		end
	end

	// Score phase pairs Q from scratchpad with K from result
	always_comb begin
		if (phase_q[TAIL] == PH_S) begin
			op_a = scratchpad_read_data;
			op_b = result_read_data;
		end else begin
			op_a = input_read_data;
			op_b = weight_read_data;
		end
	end

	assign product = op_a * op_b; // Wraps to 32 bits
	assign sum     = (first_q[TAIL] ? data_t'(0) : acc) + product;
	assign base    = restart_q[TAIL] ? addr_t'(0) : wr_cnt;

	always_ff @(posedge clk) begin
		if (valid_q[TAIL])
			acc <= sum;
		if (valid_q[TAIL] && last_q[TAIL]) begin
			write_address <= base;
			write_data    <= sum;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			write_enable <= 1'b0;
			wr_cnt       <= '0;
		end else begin
			write_enable <= valid_q[TAIL] && last_q[TAIL];
			if (valid_q[TAIL])
				wr_cnt <= last_q[TAIL] ? base + addr_t'(1) : base;
		end
	end

endmodule

`default_nettype wire

// ==== oper_if.sv ====
// Operand tag bus
`timescale 1ns/1ps
`default_nettype none

interface oper_if
	import attn_ctrl_pkg::*;
();

	logic   valid;   // Term whose addresses went out this cycle
	logic   first;
	logic   last;
	phase_t phase;
	logic   restart; // First term of a run

	modport agen (
		output valid, first, last, phase, restart
	);

	modport mac (
		input valid, first, last, phase, restart
	);

endinterface

`default_nettype wire

// ==== operand_addr_gen.sv ====
// Operand address generator
`timescale 1ns/1ps
`default_nettype none

module operand_addr_gen
	import attn_types_pkg::*, attn_ctrl_pkg::*;
(
	input  wire   clk,
	input  wire   reset_n,
	seq_if.agen   seq,
	oper_if.agen  oper,
	output addr_t input_read_address,
	output addr_t weight_read_address,
	output addr_t result_read_address,
	output addr_t scratchpad_read_address
);

	addr_t de_size, ne_size;
	addr_t in_addr, wt_addr, sp_addr, rs_addr;
	logic  restart;

	// Matrix sizes in words
	assign de_size = seq.dim_d * seq.dim_e; // One weight matrix
	assign ne_size = seq.dim_n * seq.dim_e; // One projection result

	// ------------------------------
	// Address mapping
	// ------------------------------
	always_comb begin
		in_addr = '0;
		wt_addr = '0;
		sp_addr = '0;
		rs_addr = '0;
		if (seq.issue) begin
			if (seq.phase == PH_S) begin
				sp_addr = seq.row * seq.dim_e + seq.inner;           // Q[row][inner]
				rs_addr = ne_size + seq.col * seq.dim_e + seq.inner; // K[col][inner]
			end else begin
				// Skip header word, weights stacked Wq, Wk, Wv
				in_addr = addr_t'(1) + seq.row * seq.dim_d + seq.inner;
				wt_addr = addr_t'(1) + addr_t'(seq.phase) * de_size
					+ seq.inner * seq.dim_e + seq.col;
			end
		end
	end

	assign restart = seq.issue && (seq.phase == PH_Q) && (seq.row == '0)
		&& (seq.col == '0) && (seq.inner == '0);

	// Addresses and tag leave together
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			input_read_address      <= '0;
			weight_read_address     <= '0;
			result_read_address     <= '0;
			scratchpad_read_address <= '0;
			oper.valid   <= 1'b0;
			oper.first   <= 1'b0;
			oper.last    <= 1'b0;
			oper.phase   <= PH_Q;
			oper.restart <= 1'b0;
		end else begin
			input_read_address      <= in_addr;
			weight_read_address     <= wt_addr;
			result_read_address     <= rs_addr;
			scratchpad_read_address <= sp_addr;
			oper.valid   <= seq.issue;
			oper.first   <= seq.first;
			oper.last    <= seq.last;
			oper.phase   <= seq.phase;
			oper.restart <= restart;
		end
	end

endmodule

`default_nettype wire

// ==== seq_if.sv ====
// Sequencer loop bus
`timescale 1ns/1ps
`default_nettype none

interface seq_if
	import attn_types_pkg::*, attn_ctrl_pkg::*;
();

	phase_t phase;
	dim_t   row;
	dim_t   col;
	dim_t   inner; // Position along the dot product

	// Captured dimensions
	dim_t   dim_n;
	dim_t   dim_d;
	dim_t   dim_e;

	logic   issue; // One strobe per product term
	logic   first;
	logic   last;

	modport seq (
		output phase, row, col, inner,
		output dim_n, dim_d, dim_e,
		output issue, first, last
	);

	modport agen (
		input phase, row, col, inner,
		input dim_n, dim_d, dim_e,
		input issue, first, last
	);

endinterface

`default_nettype wire

// ==== tb_attention.sv ====
// Attention front end testbench
`timescale 1ns/1ps
`default_nettype none

`include "attn_macros.svh"

module tb_attention
	import attn_types_pkg::*;
();

	localparam int RUNS      = 7; // Fixed, five random, one wrap
	localparam int MEM_WORDS = 2 ** `ADDR_WIDTH;

	logic  clk;
	logic  reset_n;
	logic  dut_valid;
	logic  dut_ready;
	addr_t input_read_address, weight_read_address;
	addr_t result_read_address, scratchpad_read_address;
	addr_t result_write_address, scratchpad_write_address;
	data_t result_write_data, scratchpad_write_data;
	logic  result_write_enable, scratchpad_write_enable;
	data_t input_read_data      = '0;
	data_t weight_read_data     = '0;
	data_t result_read_data     = '0;
	data_t scratchpad_read_data = '0;

	data_t input_mem  [MEM_WORDS];
	data_t weight_mem [MEM_WORDS];
	data_t result_mem [MEM_WORDS];
	data_t scratch_mem [MEM_WORDS];

	// Hand-worked 2x2 case, Wq is the identity
	data_t fixed_input  [4]  = '{1, 2, 3, 4};
	data_t fixed_weight [12] = '{1, 0, 0, 1, 2, -1, 0, 3, 0, 1, 1, 0};
	data_t fixed_result [16] = '{1, 2, 3, 4, 2, 5, 6, 9, 2, 1, 4, 3, 12, 24, 26, 54};

	int          run_n [RUNS];
	int          run_d [RUNS];
	int          run_e [RUNS];
	int          tb_errors, check_errors, run_writes, writes_total;
	int          cycle_count = 0;
	int          cycle_limit;
	logic [31:0] lfsr_state;

	attention_top DUT (
		.clk                      (clk),
		.reset_n                  (reset_n),
		.dut_valid                (dut_valid),
		.dut_ready                (dut_ready),
		.input_read_address       (input_read_address),
		.input_read_data          (input_read_data),
		.weight_read_address      (weight_read_address),
		.weight_read_data         (weight_read_data),
		.result_write_enable      (result_write_enable),
		.result_write_address     (result_write_address),
		.result_write_data        (result_write_data),
		.result_read_address      (result_read_address),
		.result_read_data         (result_read_data),
		.scratchpad_write_enable  (scratchpad_write_enable),
		.scratchpad_write_address (scratchpad_write_address),
		.scratchpad_write_data    (scratchpad_write_data),
		.scratchpad_read_address  (scratchpad_read_address),
		.scratchpad_read_data     (scratchpad_read_data)
	);

	attn_checker u_check (
		.clk                      (clk),
		.reset_n                  (reset_n),
		.dut_ready                (dut_ready),
		.result_write_enable      (result_write_enable),
		.result_write_address     (result_write_address),
		.result_write_data        (result_write_data),
		.scratchpad_write_enable  (scratchpad_write_enable),
		.scratchpad_write_address (scratchpad_write_address),
		.scratchpad_write_data    (scratchpad_write_data),
		.input_mem                (input_mem),
		.weight_mem               (weight_mem),
		.error_count              (check_errors),
		.run_writes               (run_writes)
	);

	always #20 clk = ~clk;

	// Memories answer one cycle after the address
	always @(posedge clk) begin
		input_read_data      <= input_mem[input_read_address];
		weight_read_data     <= weight_mem[weight_read_address];
		result_read_data     <= result_mem[result_read_address];
		scratchpad_read_data <= scratch_mem[scratchpad_read_address];
		if (result_write_enable)
			result_mem[result_write_address] <= result_write_data;
		if (scratchpad_write_enable)
			scratch_mem[scratchpad_write_address] <= scratchpad_write_data;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Timeout after %0d cycles, dut_ready never came back", cycle_count);
			$display("Test failed");
			$finish;
		end
	end

	// ------------------------------
	// Stimulus helpers
	// ------------------------------
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1
	endfunction

	task automatic draw_bits(input int width, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < width; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value      = {value[30:0], lfsr_state[0]};
		end
	endtask

	task automatic draw_value(input logic big, output data_t value);
		logic [31:0] bits;
		if (big) begin
			draw_bits(32, bits);
			value = bits;
		end else begin
			draw_bits(4, bits);
			value = {{28{bits[3]}}, bits[3:0]}; // -8 to 7
		end
	endtask

	task automatic load_matrices(input int run);
		int    n, d, e;
		data_t value;
		n = run_n[run];
		d = run_d[run];
		e = run_e[run];
		input_mem[0]  = {16'(n), 16'(d)};
		weight_mem[0] = {16'(d), 16'(e)};
		for (int i = 0; i < n * d; i++) begin
			if (run == 0)
				value = fixed_input[i];
			else
				draw_value(run == RUNS - 1, value);
			input_mem[addr_t'(1 + i)] = value;
		end
		for (int i = 0; i < 3 * d * e; i++) begin // Wq, Wk, Wv back to back
			if (run == 0)
				value = fixed_weight[i];
			else
				draw_value(run == RUNS - 1, value);
			weight_mem[addr_t'(1 + i)] = value;
		end
	endtask

	function automatic int total_errors();
		return tb_errors + check_errors;
	endfunction

	task automatic check_fixed_case();
		for (int i = 0; i < 16; i++) begin
			if (result_mem[addr_t'(i)] !== fixed_result[i]
				|| scratch_mem[addr_t'(i)] !== fixed_result[i]) begin
				$display("[FAIL] %0t: word %0d is %0d in result, %0d in scratchpad, expected %0d",
					$time, i, result_mem[addr_t'(i)], scratch_mem[addr_t'(i)], fixed_result[i]);
				tb_errors++;
			end
		end
	endtask

	task automatic run_test(input int run, input string kind);
		int errors_before;
		errors_before = total_errors();
		load_matrices(run);
		dut_valid = 1'b1;
		@(negedge clk);
		dut_valid = 1'b0;
		if (dut_ready !== 1'b0) begin
			$display("dut_ready still high at %0t, one cycle after dut_valid", $time);
			tb_errors++;
		end
		while (dut_ready !== 1'b1)
			@(negedge clk);
		@(negedge clk); // Checker closes the run on the ready edge
		if (run == 0)
			check_fixed_case();
		writes_total += run_writes;
		$display("test %0d %s N=%0d D=%0d E=%0d: %0d writes, %0d errors", run + 2, kind,
			run_n[run], run_d[run], run_e[run], run_writes, total_errors() - errors_before);
	endtask

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial begin
		logic [31:0] bits;
		clk          = 1'b0;
		reset_n      = 1'b0;
		dut_valid    = 1'b0;
		lfsr_state   = 32'h27aeffe2;
		tb_errors    = 0;
		writes_total = 0;
		run_n[0]     = 2;
		run_d[0]     = 2;
		run_e[0]     = 2;
		cycle_limit  = 0;
		for (int r = 0; r < RUNS; r++) begin
			if (r > 0) begin
				draw_bits(2, bits);
				run_n[r] = int'(bits) + 1;
				draw_bits(2, bits);
				run_d[r] = int'(bits) + 1;
				draw_bits(2, bits);
				run_e[r] = int'(bits) + 1;
			end
			cycle_limit += 4 * run_n[r] * run_e[r] * run_d[r]
				+ run_n[r] * run_n[r] * run_e[r] + 64;
		end

		repeat (10) @(negedge clk);
		reset_n = 1'b1;
		repeat (4) begin
			@(negedge clk);
			if (dut_ready !== 1'b1 || result_write_enable !== 1'b0
				|| scratchpad_write_enable !== 1'b0) begin
				$display("Idle after reset at %0t has ready low or a write enable high", $time);
				tb_errors++;
			end
		end
		$display("test 1 idle after reset: %0d errors", tb_errors);

		run_test(0, "fixed");
		for (int r = 1; r < RUNS - 1; r++)
			run_test(r, "random");
		run_test(RUNS - 1, "wrap");

		$display("%0d tests, %0d writes checked, %0d errors", RUNS + 1, writes_total,
			total_errors());
		if (total_errors() == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
